// File: compile.f
src/axil_pkg.sv
src/axil_addr_decode.sv
src/axil_demux.sv
src/axil_err_slv.sv
src/axil_mux.sv
src/axil_xbar.sv
test/tb_axil_mem.sv
test/tb_axil_xbar.sv

// File: run.sh
#!/bin/sh
# Build and run the crossbar testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_axil_xbar \
  -f compile.f -o tb_axil_xbar

# The simulator exits non-zero on failure, so the log decides
./obj_dir/tb_axil_xbar | tee sim.log || true

if grep -qx "test passed" sim.log; then
  echo "Simulation OK"
  exit 0
else
  echo "Simulation FAILED"
  exit 1
fi

// File: test/tb_axil_xbar.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the AXI4-Lite crossbar
// Two managers, three memory models,
// shadow memory and routing reference
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module tb_axil_xbar import axil_pkg::*;;

  localparam int Timeout = 50;  // Cycles per wait

  logic                       clk = 1'b0;
  logic                       rst;
  axil_req_t                  slv_req [2];
  axil_req_t  [1:0]           slv_req_bus;
  axil_resp_t [1:0]           slv_resp;
  axil_req_t  [2:0]           mst_req;
  axil_resp_t [2:0]           mst_resp;
  axil_rule_t [2:0]           addr_map;
  logic       [1:0]           en_default;
  logic       [1:0][1:0]      default_port;
  data_t                      shadow [3][64];
  int                         seed = 39;

  always #50 clk = ~clk;

  assign slv_req_bus[0] = slv_req[0];
  assign slv_req_bus[1] = slv_req[1];

  axil_xbar #(.NoSlvPorts(2), .NoMstPorts(3), .NoAddrRules(3)) i_dut (
    .clk_i                 (clk),
    .rst_i                 (rst),
    .slv_req_i             (slv_req_bus),
    .slv_resp_o            (slv_resp),
    .mst_req_o             (mst_req),
    .mst_resp_i            (mst_resp),
    .addr_map_i            (addr_map),
    .en_default_mst_port_i (en_default),
    .default_mst_port_i    (default_port)
  );

  for (genvar m = 0; m < 3; m++) begin : gen_mem
    tb_axil_mem #(.PortIdx(m)) i_mem (
      .clk_i  (clk),
      .rst_i  (rst),
      .req_i  (mst_req[m]),
      .resp_o (mst_resp[m])
    );
  end

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("** Error at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
      $display("test failed");
      $fatal(1, "Simulation stopped on mismatch");
    end
  endtask

  task automatic timeout_fail(input string what, input int s);
    $display("Timeout at %0t: no %s on slave port %0d", $time, what, s);
    $display("test failed");
    $fatal(1, "Simulation stopped on timeout");
  endtask

  // Accepted write beat must be at the master port one cycle later
  task automatic check_write_forward(input int port, input addr_t addr, input prot_t prot,
                                     input data_t data, input strb_t strb);
    check_value(mst_req[port].aw_valid, 1, "AW not forwarded after one cycle");
    check_value(mst_req[port].w_valid, 1, "W not forwarded after one cycle");
    check_value(mst_req[port].aw.addr, addr, "AW addr at master port");
    check_value(mst_req[port].aw.prot, prot, "AW prot at master port");
    check_value(mst_req[port].w.data, data, "W data at master port");
    check_value(mst_req[port].w.strb, strb, "W strb at master port");
  endtask

  task automatic check_read_forward(input int port, input addr_t addr, input prot_t prot);
    check_value(mst_req[port].ar_valid, 1, "AR not forwarded after one cycle");
    check_value(mst_req[port].ar.addr, addr, "AR addr at master port");
    check_value(mst_req[port].ar.prot, prot, "AR prot at master port");
  endtask

  // Last matching rule wins, then default, else decode error (-1)
  function automatic int expected_port(input int s, input addr_t addr);
    int port;
    port = -1;
    for (int i = 0; i < 3; i++) begin
      if ((addr >= addr_map[i].start_addr) && (addr < addr_map[i].end_addr)) begin
        port = int'(addr_map[i].idx);
      end
    end
    if ((port < 0) && en_default[s]) begin
      port = int'(default_port[s]);
    end
    return port;
  endfunction

  function automatic data_t merge_bytes(input data_t old, input data_t data, input strb_t strb);
    data_t res;
    res = old;
    for (int b = 0; b < StrbWidth; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = data[8*b +: 8];
      end
    end
    return res;
  endfunction

  // Entered and left 1 ns after a rising edge
  task automatic do_write(input int s, input int port, input addr_t addr, input data_t data,
                          input strb_t strb, output resp_code_t resp, output int lat);
    int      cnt;
    int      hold;
    axil_b_t b_seen;
    slv_req[s].aw_valid = 1'b1;
    slv_req[s].aw.addr  = addr;
    slv_req[s].aw.prot  = 3'(2 * s + 1);
    slv_req[s].w_valid  = 1'b1;
    slv_req[s].w.data   = data;
    slv_req[s].w.strb   = strb;
    cnt = 0;
    do begin
      @(negedge clk);
      cnt++;
      if (cnt > Timeout) timeout_fail("AW/W ready", s);
    end while (!(slv_resp[s].aw_ready && slv_resp[s].w_ready));
    @(posedge clk);
    #1;
    slv_req[s].aw_valid = 1'b0;
    slv_req[s].w_valid  = 1'b0;
    cnt = 0;
    do begin
      @(negedge clk);
      cnt++;
      if (cnt > Timeout) timeout_fail("B response", s);
      if (port >= 0) begin
        if (cnt == 1) check_write_forward(port, addr, 3'(2 * s + 1), data, strb);
        check_value(slv_resp[s].b_valid, mst_resp[port].b_valid,
                    "B valid at slave port vs master port");
      end
    end while (!slv_resp[s].b_valid);
    lat    = cnt;
    b_seen = slv_resp[s].b;
    hold   = $random(seed) & 3;  // Back-pressure stretch
    repeat (hold) begin
      @(negedge clk);
      check_value(slv_resp[s].b_valid, 1, "b_valid dropped before b_ready");
      check_value(slv_resp[s].b, b_seen, "B changed before b_ready");
    end
    @(posedge clk);
    #1;
    slv_req[s].b_ready = 1'b1;
    @(negedge clk);
    check_value(slv_resp[s].b_valid, 1, "b_valid low at handshake");
    resp = slv_resp[s].b.resp;
    @(posedge clk);
    #1;
    slv_req[s].b_ready = 1'b0;
  endtask

  task automatic do_read(input int s, input int port, input addr_t addr, output data_t data,
                         output resp_code_t resp, output int lat);
    int      cnt;
    int      hold;
    axil_r_t r_seen;
    slv_req[s].ar_valid = 1'b1;
    slv_req[s].ar.addr  = addr;
    slv_req[s].ar.prot  = 3'(2 * s + 1);
    cnt = 0;
    do begin
      @(negedge clk);
      cnt++;
      if (cnt > Timeout) timeout_fail("AR ready", s);
    end while (!slv_resp[s].ar_ready);
    @(posedge clk);
    #1;
    slv_req[s].ar_valid = 1'b0;
    cnt = 0;
    do begin
      @(negedge clk);
      cnt++;
      if (cnt > Timeout) timeout_fail("R response", s);
      if (port >= 0) begin
        if (cnt == 1) check_read_forward(port, addr, 3'(2 * s + 1));
        check_value(slv_resp[s].r_valid, mst_resp[port].r_valid,
                    "R valid at slave port vs master port");
      end
    end while (!slv_resp[s].r_valid);
    lat    = cnt;
    r_seen = slv_resp[s].r;
    hold   = $random(seed) & 3;
    repeat (hold) begin
      @(negedge clk);
      check_value(slv_resp[s].r_valid, 1, "r_valid dropped before r_ready");
      check_value(slv_resp[s].r, r_seen, "R changed before r_ready");
    end
    @(posedge clk);
    #1;
    slv_req[s].r_ready = 1'b1;
    @(negedge clk);
    check_value(slv_resp[s].r_valid, 1, "r_valid low at handshake");
    data = slv_resp[s].r.data;
    resp = slv_resp[s].r.resp;
    @(posedge clk);
    #1;
    slv_req[s].r_ready = 1'b0;
  endtask

  task automatic write_check(input int s, input addr_t addr, input data_t data, input strb_t strb);
    int         port;
    int         lat;
    resp_code_t resp;
    port = expected_port(s, addr);
    do_write(s, port, addr, data, strb, resp, lat);
    if (port < 0) begin
      check_value(resp, RESP_DECERR, $sformatf("B resp, unmapped write on port %0d", s));
      check_value(lat, 1, "DECERR B latency");
    end else begin
      check_value(resp, RESP_OKAY, $sformatf("B resp, write on port %0d", s));
      shadow[port][addr[7:2]] = merge_bytes(shadow[port][addr[7:2]], data, strb);
    end
  endtask

  task automatic read_check(input int s, input addr_t addr);
    int         port;
    int         lat;
    data_t      data;
    resp_code_t resp;
    port = expected_port(s, addr);
    do_read(s, port, addr, data, resp, lat);
    if (port < 0) begin
      check_value(resp, RESP_DECERR, $sformatf("R resp, unmapped read on port %0d", s));
      check_value(data, ERR_RDATA, "R data of decode error");
      check_value(lat, 1, "DECERR R latency");
    end else begin
      check_value(resp, RESP_OKAY, $sformatf("R resp, read on port %0d", s));
      check_value(data, {4'(port), shadow[port][addr[7:2]][27:0]},
                  $sformatf("R data at %h on port %0d", addr, s));
    end
  endtask

  // Even words for slave port 0, odd words for slave port 1
  task automatic random_step(input int s, input int port);
    addr_t addr;
    addr = addr_t'(port) * 32'h1000 + addr_t'((($random(seed) & 31) * 2 + s) * 4);
    if ($random(seed) & 1) begin
      write_check(s, addr, $random(seed), 4'($random(seed)));
    end else begin
      read_check(s, addr);
    end
  endtask

  initial begin
    addr_t addr;
    int    port;
    rst          = 1'b1;
    slv_req[0]   = '0;
    slv_req[1]   = '0;
    en_default   = '0;
    default_port = '0;
    // Rule 2 overlaps the top half of rule 1
    addr_map[0] = '{idx: 8'd0, start_addr: 32'h0000_0000, end_addr: 32'h0000_1000};
    addr_map[1] = '{idx: 8'd1, start_addr: 32'h0000_1000, end_addr: 32'h0000_2000};
    addr_map[2] = '{idx: 8'd2, start_addr: 32'h0000_1800, end_addr: 32'h0000_3000};
    for (int m = 0; m < 3; m++) begin
      for (int w = 0; w < 64; w++) begin
        shadow[m][w] = '0;
      end
    end
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;

    // Write and read back in every rule
    for (int s = 0; s < 2; s++) begin
      for (int r = 0; r < 3; r++) begin
        for (int k = 0; k < 2; k++) begin
          addr = addr_map[r].start_addr + addr_t'(4 * (s * 2 + k));
          write_check(s, addr, $random(seed), 4'hF);
          read_check(s, addr);
        end
      end
    end

    // Unmapped, default off
    for (int s = 0; s < 2; s++) begin
      addr = 32'h0000_4000 + addr_t'(8 * s);
      write_check(s, addr, 32'hFFFF_FFFF, 4'hF);
      read_check(s, addr);
      for (int r = 0; r < 3; r++) begin
        read_check(s, addr_map[r].start_addr + addr_t'(8 * s));  // Memory untouched
      end
    end

    // Default port on slave port 1 only
    en_default[1]   = 1'b1;
    default_port[1] = 2'd2;
    write_check(1, 32'h0000_5010, 32'h1234_5678, 4'hF);
    read_check(1, 32'h0000_5010);
    read_check(0, 32'h0000_5010);
    read_check(1, 32'h0000_2010);  // Same word through rule 2
    en_default[1] = 1'b0;

    // Partial strobes from both ports
    addr = 32'h0000_1020;
    write_check(0, addr, 32'h1122_3344, 4'hF);
    write_check(0, addr, 32'hAABB_CCDD, 4'b0101);
    write_check(1, addr, 32'h5566_7788, 4'b1000);
    read_check(0, addr);
    read_check(1, addr);

    // Both managers hit one master port together
    for (int i = 0; i < 40; i++) begin
      port = int'($unsigned($random(seed)) % 3);
      fork
        random_step(0, port);
        random_step(1, port);
      join
    end

    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: test/tb_axil_mem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory model for one master port
// Random response delay, port number in
// read data bits 31:28
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module tb_axil_mem import axil_pkg::*; #(
  parameter int unsigned PortIdx = 0
) (
  input  logic       clk_i,
  input  logic       rst_i,
  input  axil_req_t  req_i,
  output axil_resp_t resp_o
);

  data_t      mem [64];
  logic       w_busy_q;
  logic [1:0] w_wait_q;
  logic       r_busy_q;
  logic [1:0] r_wait_q;
  data_t      rdata_q;
  logic       w_accept;
  logic       r_accept;
  logic [5:0] w_word;
  logic [5:0] r_word;
  int         seed = 39;

  assign w_accept = req_i.aw_valid & req_i.w_valid & ~w_busy_q;
  assign r_accept = req_i.ar_valid & ~r_busy_q;
  assign w_word   = req_i.aw.addr[7:2];
  assign r_word   = req_i.ar.addr[7:2];

  always @(posedge clk_i) begin
    if (rst_i) begin
      w_busy_q <= 1'b0;
      w_wait_q <= '0;
      r_busy_q <= 1'b0;
      r_wait_q <= '0;
      rdata_q  <= '0;
      for (int i = 0; i < 64; i++) begin
        mem[i] <= '0;
      end
    end else begin
      if (w_accept) begin
        w_busy_q <= 1'b1;
        w_wait_q <= 2'($random(seed));  // 0 to 3 cycles until B
        for (int b = 0; b < StrbWidth; b++) begin
          if (req_i.w.strb[b]) begin
            mem[w_word][8*b +: 8] <= req_i.w.data[8*b +: 8];
          end
        end
      end else if (w_busy_q && (w_wait_q != 2'd0)) begin
        w_wait_q <= w_wait_q - 2'd1;
      end else if (w_busy_q && req_i.b_ready) begin
        w_busy_q <= 1'b0;
      end
      if (r_accept) begin
        r_busy_q <= 1'b1;
        r_wait_q <= 2'($random(seed));
        rdata_q  <= {4'(PortIdx), mem[r_word][27:0]};  // Stamp the port
      end else if (r_busy_q && (r_wait_q != 2'd0)) begin
        r_wait_q <= r_wait_q - 2'd1;
      end else if (r_busy_q && req_i.r_ready) begin
        r_busy_q <= 1'b0;
      end
    end
  end

  always_comb begin
    resp_o          = '0;
    resp_o.aw_ready = w_accept;
    resp_o.w_ready  = w_accept;
    resp_o.b_valid  = w_busy_q & (w_wait_q == 2'd0);
    resp_o.b.resp   = RESP_OKAY;
    resp_o.ar_ready = r_accept;
    resp_o.r_valid  = r_busy_q & (r_wait_q == 2'd0);
    resp_o.r.data   = rdata_q;
    resp_o.r.resp   = RESP_OKAY;
  end

endmodule

`default_nettype wire

// File: src/axil_xbar.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4-Lite crossbar top level
// Decoders, demuxes and error responders
// per slave port, one mux per master port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module axil_xbar import axil_pkg::*; #(
  parameter int unsigned NoSlvPorts   = 2,
  parameter int unsigned NoMstPorts   = 3,
  parameter int unsigned NoAddrRules  = 3,
  localparam int unsigned MstIdxWidth = (NoMstPorts > 1) ? $clog2(NoMstPorts) : 1
) (
  input  logic                                      clk_i,
  input  logic                                      rst_i,
  input  axil_req_t  [NoSlvPorts-1:0]               slv_req_i,
  output axil_resp_t [NoSlvPorts-1:0]               slv_resp_o,
  output axil_req_t  [NoMstPorts-1:0]               mst_req_o,
  input  axil_resp_t [NoMstPorts-1:0]               mst_resp_i,
  input  axil_rule_t [NoAddrRules-1:0]              addr_map_i,
  input  logic       [NoSlvPorts-1:0]               en_default_mst_port_i,
  input  logic       [NoSlvPorts-1:0][MstIdxWidth-1:0] default_mst_port_i
);

  // One extra select value for the error port
  localparam int unsigned SelWidth = $clog2(NoMstPorts + 1);

  axil_req_t  [NoSlvPorts-1:0][NoMstPorts:0]   demux_reqs;
  axil_resp_t [NoSlvPorts-1:0][NoMstPorts:0]   demux_resps;
  axil_req_t  [NoMstPorts-1:0][NoSlvPorts-1:0] mux_reqs;
  axil_resp_t [NoMstPorts-1:0][NoSlvPorts-1:0] mux_resps;

  for (genvar s = 0; s < NoSlvPorts; s++) begin : gen_slv_port
    logic [MstIdxWidth-1:0] aw_dec_idx;
    logic [MstIdxWidth-1:0] ar_dec_idx;
    logic                   aw_dec_err;
    logic                   ar_dec_err;
    logic [SelWidth-1:0]    aw_sel;
    logic [SelWidth-1:0]    ar_sel;

    axil_addr_decode #(.NoMstPorts(NoMstPorts), .NoAddrRules(NoAddrRules)) i_aw_decode (
      .addr_i           (slv_req_i[s].aw.addr),
      .addr_map_i       (addr_map_i),
      .en_default_idx_i (en_default_mst_port_i[s]),
      .default_idx_i    (default_mst_port_i[s]),
      .idx_o            (aw_dec_idx),
      .dec_error_o      (aw_dec_err)
    );

    axil_addr_decode #(.NoMstPorts(NoMstPorts), .NoAddrRules(NoAddrRules)) i_ar_decode (
      .addr_i           (slv_req_i[s].ar.addr),
      .addr_map_i       (addr_map_i),
      .en_default_idx_i (en_default_mst_port_i[s]),
      .default_idx_i    (default_mst_port_i[s]),
      .idx_o            (ar_dec_idx),
      .dec_error_o      (ar_dec_err)
    );

    assign aw_sel = aw_dec_err ? SelWidth'(NoMstPorts) : SelWidth'(aw_dec_idx);
    assign ar_sel = ar_dec_err ? SelWidth'(NoMstPorts) : SelWidth'(ar_dec_idx);

    axil_demux #(.NoMstPorts(NoMstPorts + 1)) i_demux (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .slv_req_i   (slv_req_i[s]),
      .slv_resp_o  (slv_resp_o[s]),
      .aw_select_i (aw_sel),
      .ar_select_i (ar_sel),
      .mst_reqs_o  (demux_reqs[s]),
      .mst_resps_i (demux_resps[s])
    );

    // Last demux output is the error path
    axil_err_slv i_err_slv (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .slv_req_i  (demux_reqs[s][NoMstPorts]),
      .slv_resp_o (demux_resps[s][NoMstPorts])
    );

    for (genvar m = 0; m < NoMstPorts; m++) begin : gen_cross
      assign mux_reqs[m][s]    = demux_reqs[s][m];
      assign demux_resps[s][m] = mux_resps[m][s];
    end
  end

  for (genvar m = 0; m < NoMstPorts; m++) begin : gen_mst_port
    axil_mux #(.NoSlvPorts(NoSlvPorts)) i_mux (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .slv_reqs_i  (mux_reqs[m]),
      .slv_resps_o (mux_resps[m]),
      .mst_req_o   (mst_req_o[m]),
      .mst_resp_i  (mst_resp_i[m])
    );
  end

endmodule

`default_nettype wire

// File: src/axil_mux.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Master port multiplexer
// Round-robin arbitration between slave
// ports with registered request beats
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module axil_mux import axil_pkg::*; #(
  parameter int unsigned NoSlvPorts = 2,
  localparam int unsigned IdxWidth  = (NoSlvPorts > 1) ? $clog2(NoSlvPorts) : 1
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  axil_req_t  [NoSlvPorts-1:0]  slv_reqs_i,
  output axil_resp_t [NoSlvPorts-1:0]  slv_resps_o,
  output axil_req_t                    mst_req_o,
  input  axil_resp_t                   mst_resp_i
);

  logic                w_busy_q;
  logic                aw_pend_q;
  logic                w_pend_q;
  logic [IdxWidth-1:0] w_idx_q;
  logic [IdxWidth-1:0] w_rr_q;
  axil_aw_t            aw_q;
  axil_w_t             w_q;

  logic                r_busy_q;
  logic                ar_pend_q;
  logic [IdxWidth-1:0] r_idx_q;
  logic [IdxWidth-1:0] r_rr_q;
  axil_ar_t            ar_q;

  logic [NoSlvPorts-1:0] w_reqs;
  logic [NoSlvPorts-1:0] r_reqs;
  logic                  w_gnt;
  logic                  r_gnt;
  logic [IdxWidth-1:0]   w_gnt_idx;
  logic [IdxWidth-1:0]   r_gnt_idx;
  logic                  b_done;
  logic                  r_done;

  // First requester at or after ptr, MSB flags a hit
  function automatic logic [IdxWidth:0] rr_pick(input logic [NoSlvPorts-1:0] reqs,
                                                input logic [IdxWidth-1:0]   ptr);
    logic [IdxWidth:0] pick;
    int unsigned       cand;
    pick = '0;
    for (int unsigned k = 0; k < NoSlvPorts; k++) begin
      cand = ptr + k;
      if (cand >= NoSlvPorts) cand = cand - NoSlvPorts;
      if (reqs[cand] && !pick[IdxWidth]) pick = {1'b1, IdxWidth'(cand)};
    end
    return pick;
  endfunction

  function automatic logic [IdxWidth-1:0] next_ptr(input logic [IdxWidth-1:0] idx);
    return (idx == IdxWidth'(NoSlvPorts - 1)) ? '0 : idx + 1'b1;
  endfunction

  always_comb begin
    for (int unsigned s = 0; s < NoSlvPorts; s++) begin
      w_reqs[s] = slv_reqs_i[s].aw_valid & slv_reqs_i[s].w_valid;
      r_reqs[s] = slv_reqs_i[s].ar_valid;
    end
  end

  // Grant only while idle in that direction
  assign {w_gnt, w_gnt_idx} = w_busy_q ? '0 : rr_pick(w_reqs, w_rr_q);
  assign {r_gnt, r_gnt_idx} = r_busy_q ? '0 : rr_pick(r_reqs, r_rr_q);

  assign b_done = mst_resp_i.b_valid & mst_req_o.b_ready;
  assign r_done = mst_resp_i.r_valid & mst_req_o.r_ready;

  always_comb begin
    mst_req_o          = '0;
    mst_req_o.aw_valid = aw_pend_q;
    mst_req_o.aw       = aw_q;
    mst_req_o.w_valid  = w_pend_q;
    mst_req_o.w        = w_q;
    // B only once both AW and W are through
    mst_req_o.b_ready  = w_busy_q & ~aw_pend_q & ~w_pend_q & slv_reqs_i[w_idx_q].b_ready;
    mst_req_o.ar_valid = ar_pend_q;
    mst_req_o.ar       = ar_q;
    mst_req_o.r_ready  = r_busy_q & ~ar_pend_q & slv_reqs_i[r_idx_q].r_ready;
  end

  always_comb begin
    for (int unsigned s = 0; s < NoSlvPorts; s++) begin
      slv_resps_o[s]          = '0;
      slv_resps_o[s].aw_ready = w_gnt & (w_gnt_idx == IdxWidth'(s));
      slv_resps_o[s].w_ready  = w_gnt & (w_gnt_idx == IdxWidth'(s));
      slv_resps_o[s].b_valid  = w_busy_q & ~aw_pend_q & ~w_pend_q
                                & (w_idx_q == IdxWidth'(s)) & mst_resp_i.b_valid;
      slv_resps_o[s].b        = mst_resp_i.b;
      slv_resps_o[s].ar_ready = r_gnt & (r_gnt_idx == IdxWidth'(s));
      slv_resps_o[s].r_valid  = r_busy_q & ~ar_pend_q
                                & (r_idx_q == IdxWidth'(s)) & mst_resp_i.r_valid;
      slv_resps_o[s].r        = mst_resp_i.r;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      w_busy_q  <= 1'b0;
      aw_pend_q <= 1'b0;
      w_pend_q  <= 1'b0;
      w_idx_q   <= '0;
      w_rr_q    <= '0;
    end else if (w_gnt) begin
      w_busy_q  <= 1'b1;
      aw_pend_q <= 1'b1;
      w_pend_q  <= 1'b1;
      w_idx_q   <= w_gnt_idx;
      w_rr_q    <= next_ptr(w_gnt_idx);  // Winner goes to the back
    end else begin
      if (aw_pend_q && mst_resp_i.aw_ready) aw_pend_q <= 1'b0;
      if (w_pend_q && mst_resp_i.w_ready) w_pend_q <= 1'b0;
      if (b_done) w_busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      r_busy_q  <= 1'b0;
      ar_pend_q <= 1'b0;
      r_idx_q   <= '0;
      r_rr_q    <= '0;
    end else if (r_gnt) begin
      r_busy_q  <= 1'b1;
      ar_pend_q <= 1'b1;
      r_idx_q   <= r_gnt_idx;
      r_rr_q    <= next_ptr(r_gnt_idx);
    end else begin
      if (ar_pend_q && mst_resp_i.ar_ready) ar_pend_q <= 1'b0;
      if (r_done) r_busy_q <= 1'b0;
    end
  end

  // Beat holding registers
  always_ff @(posedge clk_i) begin
    if (w_gnt) begin
      aw_q <= slv_reqs_i[w_gnt_idx].aw;
      w_q  <= slv_reqs_i[w_gnt_idx].w;
    end
    if (r_gnt) ar_q <= slv_reqs_i[r_gnt_idx].ar;
  end

endmodule

`default_nettype wire

// File: src/axil_err_slv.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode error responder
// Answers every write and read with DECERR
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module axil_err_slv import axil_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  input  axil_req_t  slv_req_i,
  output axil_resp_t slv_resp_o
);

  logic b_pend_q;
  logic r_pend_q;
  logic w_accept;
  logic r_accept;

  assign w_accept = slv_req_i.aw_valid & slv_req_i.w_valid & ~b_pend_q;
  assign r_accept = slv_req_i.ar_valid & ~r_pend_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      b_pend_q <= 1'b0;
      r_pend_q <= 1'b0;
    end else begin
      if (w_accept) begin
        b_pend_q <= 1'b1;
      end else if (slv_req_i.b_ready) begin
        b_pend_q <= 1'b0;  // Response taken
      end
      if (r_accept) begin
        r_pend_q <= 1'b1;
      end else if (slv_req_i.r_ready) begin
        r_pend_q <= 1'b0;
      end
    end
  end

  always_comb begin
    slv_resp_o          = '0;
    slv_resp_o.aw_ready = w_accept;
    slv_resp_o.w_ready  = w_accept;
    slv_resp_o.b_valid  = b_pend_q;
    slv_resp_o.b.resp   = RESP_DECERR;
    slv_resp_o.ar_ready = r_accept;
    slv_resp_o.r_valid  = r_pend_q;
    slv_resp_o.r.data   = ERR_RDATA;
    slv_resp_o.r.resp   = RESP_DECERR;
  end

endmodule

`default_nettype wire

// File: src/axil_demux.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Slave port demultiplexer
// Steers each request to one output port
// and returns that port's response
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module axil_demux import axil_pkg::*; #(
  parameter int unsigned NoMstPorts = 4,  // Includes the error port
  localparam int unsigned SelWidth  = (NoMstPorts > 1) ? $clog2(NoMstPorts) : 1
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  axil_req_t                    slv_req_i,
  output axil_resp_t                   slv_resp_o,
  input  logic       [SelWidth-1:0]    aw_select_i,
  input  logic       [SelWidth-1:0]    ar_select_i,
  output axil_req_t  [NoMstPorts-1:0]  mst_reqs_o,
  input  axil_resp_t [NoMstPorts-1:0]  mst_resps_i
);

  logic                w_busy_q;
  logic [SelWidth-1:0] w_sel_q;
  logic                r_busy_q;
  logic [SelWidth-1:0] r_sel_q;

  logic w_req;
  logic r_req;
  logic w_accept;
  logic r_accept;
  logic b_done;
  logic r_done;

  // AW and W only go out as a pair
  assign w_req = slv_req_i.aw_valid & slv_req_i.w_valid & ~w_busy_q;
  assign r_req = slv_req_i.ar_valid & ~r_busy_q;

  assign w_accept = w_req & mst_resps_i[aw_select_i].aw_ready
                          & mst_resps_i[aw_select_i].w_ready;
  assign r_accept = r_req & mst_resps_i[ar_select_i].ar_ready;

  assign b_done = w_busy_q & mst_resps_i[w_sel_q].b_valid & slv_req_i.b_ready;
  assign r_done = r_busy_q & mst_resps_i[r_sel_q].r_valid & slv_req_i.r_ready;

  // Payload fans out to all ports, only handshakes are steered
  always_comb begin
    for (int unsigned j = 0; j < NoMstPorts; j++) begin
      mst_reqs_o[j]          = slv_req_i;
      mst_reqs_o[j].aw_valid = w_req & (aw_select_i == SelWidth'(j));
      mst_reqs_o[j].w_valid  = w_req & (aw_select_i == SelWidth'(j));
      mst_reqs_o[j].b_ready  = w_busy_q & slv_req_i.b_ready & (w_sel_q == SelWidth'(j));
      mst_reqs_o[j].ar_valid = r_req & (ar_select_i == SelWidth'(j));
      mst_reqs_o[j].r_ready  = r_busy_q & slv_req_i.r_ready & (r_sel_q == SelWidth'(j));
    end
  end

  always_comb begin
    slv_resp_o          = '0;
    slv_resp_o.aw_ready = w_accept;
    slv_resp_o.w_ready  = w_accept;
    slv_resp_o.b_valid  = w_busy_q & mst_resps_i[w_sel_q].b_valid;
    slv_resp_o.b        = mst_resps_i[w_sel_q].b;
    slv_resp_o.ar_ready = r_accept;
    slv_resp_o.r_valid  = r_busy_q & mst_resps_i[r_sel_q].r_valid;
    slv_resp_o.r        = mst_resps_i[r_sel_q].r;
  end

  // Write direction, one outstanding
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      w_busy_q <= 1'b0;
      w_sel_q  <= '0;
    end else if (w_accept) begin
      w_busy_q <= 1'b1;
      w_sel_q  <= aw_select_i;  // Remember where B comes from
    end else if (b_done) begin
      w_busy_q <= 1'b0;
    end
  end

  // Read direction, one outstanding
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      r_busy_q <= 1'b0;
      r_sel_q  <= '0;
    end else if (r_accept) begin
      r_busy_q <= 1'b1;
      r_sel_q  <= ar_select_i;
    end else if (r_done) begin
      r_busy_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: src/axil_addr_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address decoder
// Maps an address to a master port index
// or flags a decode error
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module axil_addr_decode import axil_pkg::*; #(
  parameter int unsigned NoMstPorts  = 3,
  parameter int unsigned NoAddrRules = 3,
  localparam int unsigned IdxWidth   = (NoMstPorts > 1) ? $clog2(NoMstPorts) : 1
) (
  input  addr_t                        addr_i,
  input  axil_rule_t [NoAddrRules-1:0] addr_map_i,
  input  logic                         en_default_idx_i,
  input  logic       [IdxWidth-1:0]    default_idx_i,
  output logic       [IdxWidth-1:0]    idx_o,
  output logic                         dec_error_o
);

  logic                match;
  logic [IdxWidth-1:0] match_idx;

  // Later rules override earlier ones
  always_comb begin
    match     = 1'b0;
    match_idx = '0;
    for (int unsigned i = 0; i < NoAddrRules; i++) begin
      if ((addr_i >= addr_map_i[i].start_addr) && (addr_i < addr_map_i[i].end_addr)) begin
        match     = 1'b1;
        match_idx = addr_map_i[i].idx[IdxWidth-1:0];
      end
    end
  end

  always_comb begin
    dec_error_o = 1'b0;
    if (match) begin
      idx_o = match_idx;
    end else if (en_default_idx_i) begin
      idx_o = default_idx_i;  // Fall back to default port
    end else begin
      idx_o       = '0;
      dec_error_o = 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: src/axil_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4-Lite crossbar common definitions
// Bus widths, response codes, channel and
// request/response structs, address rules
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package axil_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8; // One strobe per byte lane

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;
  typedef logic [2:0]           prot_t;
  typedef logic [1:0]           resp_code_t;

  localparam resp_code_t RESP_OKAY   = 2'b00;
  localparam resp_code_t RESP_DECERR = 2'b11;

  // Easy to spot in a waveform
  localparam data_t ERR_RDATA = 32'hBADC_AB1E;

  typedef struct packed {
    addr_t addr;
    prot_t prot;
  } axil_aw_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } axil_w_t;

  typedef struct packed {
    resp_code_t resp;
  } axil_b_t;

  typedef struct packed {
    addr_t addr;
    prot_t prot;
  } axil_ar_t;

  typedef struct packed {
    data_t      data;
    resp_code_t resp;
  } axil_r_t;

  // Manager side of a port
  typedef struct packed {
    logic     aw_valid;
    axil_aw_t aw;
    logic     w_valid;
    axil_w_t  w;
    logic     b_ready;
    logic     ar_valid;
    axil_ar_t ar;
    logic     r_ready;
  } axil_req_t;

  // Subordinate side of a port
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    logic    b_valid;
    axil_b_t b;
    logic    ar_ready;
    logic    r_valid;
    axil_r_t r;
  } axil_resp_t;

  // Range is [start_addr, end_addr)
  typedef struct packed {
    logic [7:0] idx;
    addr_t      start_addr;
    addr_t      end_addr;
  } axil_rule_t;

endpackage

`default_nettype wire
